// ==== flist.f ====
src/FifoPkg.sv
src/SdpBramSlice.sv
src/SyncFifoController.sv
src/WbFifoRegs.sv
src/StreamPopAdapter.sv
src/WbFifoTop.sv
verif/tbWbFifoTop.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f flist.f \
	--top-module tbWbFifoTop -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/VtbWbFifoTop)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
	exit 0
else
	exit 1
fi

// ==== verif/tbWbFifoTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbWbFifoTop;

	localparam int ClkPeriod = 8;
	localparam int TxWords = 200;
	// fifo keeps one entry free and the adapter holder takes one more
	localparam int BpWords = FifoPkg::FifoDepth - 1 + 1;
	localparam int RxOps = 160;
	localparam int OvfWords = 20;
	localparam int TotalWords = TxWords + BpWords + 1 + RxOps + FifoPkg::FifoDepth
		+ 2 * OvfWords + 4;
	localparam int TimeoutCycles = TotalWords * 40;

	logic iCLK = 1'b0;
	logic inARST;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	FifoPkg::tWbAdr wbAdr;
	FifoPkg::tData wbDatW;
	wire FifoPkg::tData wbDatR;
	wire logic wbAck;
	FifoPkg::tData rxData;
	logic rxWe;
	wire logic rxFull;
	wire FifoPkg::tData txData;
	wire logic txValid;
	logic txReady;

	// model queues
	FifoPkg::tData txQ[$];
	FifoPkg::tData rxQ[$];
	integer seed;
	logic [31:0] rnd;
	logic [31:0] readyRnd;
	logic readyNext;
	// 0 random, 1 held low, 2 held high
	int readyMode = 0;
	int errCount = 0;
	int checkCount = 0;
	logic holdPending = 1'b0;
	FifoPkg::tData heldData;
	FifoPkg::tData sinkWord;
	FifoPkg::tData rdWord;
	FifoPkg::tData expWord;

	WbFifoTop u_dut
	(
		.iCLK(iCLK),
		.inARST(inARST),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.rxData(rxData),
		.rxWe(rxWe),
		.rxFull(rxFull),
		.txData(txData),
		.txValid(txValid),
		.txReady(txReady)
	);

	always #(ClkPeriod / 2) iCLK = ~iCLK;

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic checkData(input string name, input FifoPkg::tData exp,
		input FifoPkg::tData act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkStatus(input string name, input FifoPkg::tData exp,
		input FifoPkg::tData act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("** Error at %0t ns: %s status expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// expected status word from the four flags
	function automatic FifoPkg::tData buildStatus(input logic txF, input logic txE,
		input logic rxF, input logic rxE);
		FifoPkg::tData s;
		s = '0;
		s[FifoPkg::StTxFull] = txF;
		s[FifoPkg::StTxEmpty] = txE;
		s[FifoPkg::StRxFull] = rxF;
		s[FifoPkg::StRxEmpty] = rxE;
		return s;
	endfunction

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	// all helpers start and end 1 ns after a rising edge
	task automatic tick;
		@(posedge iCLK);
		#1;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) tick();
	endtask

	task automatic wbStart(input logic we, input FifoPkg::tWbAdr adr, input FifoPkg::tData dat);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = dat;
	endtask

	task automatic waitAck;
		tick();
		while (wbAck !== 1'b1)
		begin
			tick();
		end
	endtask

	// hold through the ack edge and then release
	task automatic wbEnd;
		tick();
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(input FifoPkg::tWbAdr adr, input FifoPkg::tData dat);
		wbStart(1'b1, adr, dat);
		waitAck();
		wbEnd();
		if (adr == FifoPkg::AdrData)
		begin
			txQ.push_back(dat);
		end
	endtask

	task automatic wbRead(input FifoPkg::tWbAdr adr, output FifoPkg::tData dat);
		wbStart(1'b0, adr, '0);
		waitAck();
		dat = wbDatR;
		wbEnd();
	endtask

	// one cycle of rxWe while the model drops the word when full
	task automatic pushRx(input FifoPkg::tData dat);
		checkFlag("rxFull", rxQ.size() == FifoPkg::FifoDepth - 1, rxFull);
		rxData = dat;
		rxWe = 1'b1;
		if (rxQ.size() < FifoPkg::FifoDepth - 1)
		begin
			rxQ.push_back(dat);
		end
		tick();
		rxWe = 1'b0;
	endtask

	// data read checked against the receive model or zero when empty
	task automatic readRxChecked;
		wbRead(FifoPkg::AdrData, rdWord);
		expWord = '0;
		if (rxQ.size() > 0)
		begin
			expWord = rxQ.pop_front();
		end
		checkData("wbDatR", expWord, rdWord);
	endtask

	task automatic waitTxDrain;
		while (txQ.size() != 0)
		begin
			tick();
		end
	endtask

	// ----------------------------------------
	// stream sink and ready driver
	// ----------------------------------------
	initial
	begin
		txReady = 1'b0;
		forever
		begin
			// next ready value picked mid cycle
			@(negedge iCLK);
			readyRnd = $random(seed);
			case (readyMode)
				0: readyNext = readyRnd[0];
				1: readyNext = 1'b0;
				default: readyNext = 1'b1;
			endcase
			@(posedge iCLK);
			#1;
			txReady = readyNext;
		end
	end

	// mid cycle sampling with both stream sides settled
	initial
	begin
		forever
		begin
			@(negedge iCLK);
			if (inARST === 1'b1)
			begin
				// stalled word must not move
				if (holdPending)
				begin
					checkFlag("txValid", 1'b1, txValid);
					checkData("txData", heldData, txData);
				end
				if (txValid && txReady)
				begin
					if (txQ.size() == 0)
					begin
						errCount++;
						$display("transmit stream gave word %h at %0t ns with none expected",
							txData, $time);
					end
					else
					begin
						sinkWord = txQ.pop_front();
						checkData("txData", sinkWord, txData);
					end
				end
				holdPending = txValid && !txReady;
				heldData = txData;
			end
		end
	end

	// watchdog
	initial
	begin
		#(TimeoutCycles * ClkPeriod);
		$display("run did not finish within %0d cycles, a handshake never completed",
			TimeoutCycles);
		$display("Errors found");
		$finish;
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		seed = 32'h9c42;
		inARST = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		rxData = '0;
		rxWe = 1'b0;
		repeat (8) @(posedge iCLK);
		#1;
		inARST = 1'b1;

		// reset state
		checkFlag("txValid", 1'b0, txValid);
		checkFlag("rxFull", 1'b0, rxFull);
		wbRead(FifoPkg::AdrStatus, rdWord);
		checkStatus("wbDatR", buildStatus(1'b0, 1'b1, 1'b0, 1'b1), rdWord);

		// transmit ordering with ready toggling at random
		readyMode = 0;
		for (int i = 0; i < TxWords; i++)
		begin
			rnd = $random(seed);
			wbWrite(FifoPkg::AdrData, rnd[15:0]);
		end
		waitTxDrain();
		checkFlag("txValid", 1'b0, txValid);

		// transmit back-pressure
		readyMode = 1;
		idleCycles(2);
		for (int i = 0; i < BpWords; i++)
		begin
			rnd = $random(seed);
			wbWrite(FifoPkg::AdrData, rnd[15:0]);
		end
		idleCycles(4);
		wbRead(FifoPkg::AdrStatus, rdWord);
		checkStatus("wbDatR", buildStatus(1'b1, 1'b0, 1'b0, 1'b1), rdWord);
		checkFlag("txValid", 1'b1, txValid);
		// one more write stalls until the stream moves
		rnd = $random(seed);
		wbStart(1'b1, FifoPkg::AdrData, rnd[15:0]);
		repeat (20)
		begin
			tick();
			checkFlag("wbAck", 1'b0, wbAck);
		end
		readyMode = 2;
		waitAck();
		wbEnd();
		txQ.push_back(rnd[15:0]);
		waitTxDrain();
		readyMode = 0;

		// receive ordering with gaps and interleaved reads
		for (int i = 0; i < RxOps; i++)
		begin
			rnd = $random(seed);
			if (rnd[2:0] < 3'd5)
			begin
				pushRx(rnd[31:16]);
			end
			else
			begin
				readRxChecked();
			end
			idleCycles(int'(rnd[4:3]));
		end
		while (rxQ.size() != 0)
		begin
			readRxChecked();
		end
		readRxChecked();

		// receive overflow without reads
		for (int i = 0; i < OvfWords; i++)
		begin
			rnd = $random(seed);
			pushRx(rnd[15:0]);
		end
		checkFlag("rxFull", 1'b1, rxFull);
		for (int i = 0; i < FifoPkg::FifoDepth; i++)
		begin
			readRxChecked();
		end
		wbRead(FifoPkg::AdrStatus, rdWord);
		checkStatus("wbDatR", buildStatus(1'b0, 1'b1, 1'b0, 1'b1), rdWord);

		idleCycles(4);
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/WbFifoTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module WbFifoTop
(
	input wire logic iCLK,
	input wire logic inARST,
	// wishbone classic slave
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire FifoPkg::tWbAdr wbAdr,
	input wire FifoPkg::tData wbDatW,
	output wire FifoPkg::tData wbDatR,
	output wire logic wbAck,
	// receive stream in
	input wire FifoPkg::tData rxData,
	input wire logic rxWe,
	output wire logic rxFull,
	// transmit stream out
	output wire FifoPkg::tData txData,
	output wire logic txValid,
	input wire logic txReady
);

	// ----------------------------------------
	// transmit path nets
	// ----------------------------------------
	wire logic txPush;
	wire FifoPkg::tData txPushData;
	wire logic txFifoFull;
	wire logic txFifoEmpty;
	wire logic txFifoPop;
	wire FifoPkg::tData txFifoRd;
	wire logic txFifoRvd;

	// receive path nets
	wire logic rxPop;
	wire FifoPkg::tData rxPopData;
	wire logic rxPopValid;
	wire logic rxFifoEmpty;

	// bus registers
	WbFifoRegs uRegs
	(
		.iCLK(iCLK),
		.inARST(inARST),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.txPush(txPush),
		.txPushData(txPushData),
		.txFull(txFifoFull),
		.txEmpty(txFifoEmpty),
		.rxPop(rxPop),
		.rxPopData(rxPopData),
		.rxPopValid(rxPopValid),
		.rxFull(rxFull),
		.rxEmpty(rxFifoEmpty)
	);

	// transmit fifo, bus in, adapter out
	SyncFifoController uTxFifo
	(
		.iCLK(iCLK),
		.inARST(inARST),
		.iWd(txPushData),
		.iWe(txPush),
		.oFull(txFifoFull),
		.oRd(txFifoRd),
		.iRe(txFifoPop),
		.oRvd(txFifoRvd),
		.oEmp(txFifoEmpty)
	);

	// receive fifo, overflow words dropped by its own gating
	SyncFifoController uRxFifo
	(
		.iCLK(iCLK),
		.inARST(inARST),
		.iWd(rxData),
		.iWe(rxWe),
		.oFull(rxFull),
		.oRd(rxPopData),
		.iRe(rxPop),
		.oRvd(rxPopValid),
		.oEmp(rxFifoEmpty)
	);

	// transmit stream driver
	StreamPopAdapter uTxAdapter
	(
		.iCLK(iCLK),
		.inARST(inARST),
		.fifoPop(txFifoPop),
		.fifoEmp(txFifoEmpty),
		.fifoRd(txFifoRd),
		.fifoRvd(txFifoRvd),
		.txData(txData),
		.txValid(txValid),
		.txReady(txReady)
	);

endmodule

`default_nettype wire

// ==== src/StreamPopAdapter.sv ====
`timescale 1ns/10ps
`default_nettype none

module StreamPopAdapter
(
	input wire logic iCLK,
	input wire logic inARST,
	// fifo read side
	output logic fifoPop,
	input wire logic fifoEmp,
	input wire FifoPkg::tData fifoRd,
	input wire logic fifoRvd,
	// outgoing stream
	output FifoPkg::tData txData,
	output logic txValid,
	input wire logic txReady
);

	// one pop issued, word not back yet
	logic inFlight;
	// holder empty now or emptied at this edge
	logic holderFree;

	assign holderFree = ~txValid | txReady;

	// only one pop at a time
	// the word lands after the holder has drained
	assign fifoPop = holderFree & ~inFlight & ~fifoEmp;

	// ----------------------------------------
	// pop tracking
	// ----------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			inFlight <= 1'b0;
		end
		else if (fifoPop)
		begin
			inFlight <= 1'b1;
		end
		else if (fifoRvd)
		begin
			inFlight <= 1'b0;
		end
	end

	// holder valid flag
	// load wins, the holder is always empty when the word returns
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			txValid <= 1'b0;
		end
		else if (fifoRvd)
		begin
			txValid <= 1'b1;
		end
		else if (txReady)
		begin
			txValid <= 1'b0;
		end
	end

	// holder data, stable until the next returned word
	always_ff @(posedge iCLK)
	begin
		if (fifoRvd)
		begin
			txData <= fifoRd;
		end
	end

endmodule

`default_nettype wire

// ==== src/WbFifoRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module WbFifoRegs
(
	input wire logic iCLK,
	input wire logic inARST,
	// wishbone classic slave
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire FifoPkg::tWbAdr wbAdr,
	input wire FifoPkg::tData wbDatW,
	output FifoPkg::tData wbDatR,
	output logic wbAck,
	// transmit fifo push side
	output logic txPush,
	output FifoPkg::tData txPushData,
	input wire logic txFull,
	input wire logic txEmpty,
	// receive fifo pop side
	output logic rxPop,
	input wire FifoPkg::tData rxPopData,
	input wire logic rxPopValid,
	input wire logic rxFull,
	input wire logic rxEmpty
);

	FifoPkg::tWbState state;
	FifoPkg::tWbState stateNext;
	// valid bus request this cycle
	logic busReq;
	// read data register load
	logic datLoad;
	FifoPkg::tData datNext;
	// flags packed for the status register
	FifoPkg::tData statusWord;

	assign busReq = wbCyc & wbStb;

	// bus data goes straight to the fifo, push qualifies it
	assign txPushData = wbDatW;

	// ack lasts exactly the StAck cycle
	assign wbAck = (state == FifoPkg::StAck);

	// status word assembly
	always_comb
	begin
		statusWord = '0;
		statusWord[FifoPkg::StTxFull] = txFull;
		statusWord[FifoPkg::StTxEmpty] = txEmpty;
		statusWord[FifoPkg::StRxFull] = rxFull;
		statusWord[FifoPkg::StRxEmpty] = rxEmpty;
	end

	// ----------------------------------------
	// bus fsm
	// ----------------------------------------
	always_comb
	begin
		stateNext = state;
		txPush = 1'b0;
		rxPop = 1'b0;
		datLoad = 1'b0;
		datNext = '0;
		case (state)
			FifoPkg::StIdle:
			begin
				if (busReq && wbWe)
				begin
					// data write waits while tx is full, this is the stall
					if (wbAdr != FifoPkg::AdrData)
					begin
						stateNext = FifoPkg::StAck;
					end
					else if (!txFull)
					begin
						txPush = 1'b1;
						stateNext = FifoPkg::StAck;
					end
				end
				else if (busReq)
				begin
					if (wbAdr == FifoPkg::AdrData && !rxEmpty)
					begin
						// pop now, data comes back with rxPopValid
						rxPop = 1'b1;
						stateNext = FifoPkg::StPopWait;
					end
					else
					begin
						// status read, empty data read or unmapped address
						datLoad = 1'b1;
						if (wbAdr == FifoPkg::AdrStatus)
						begin
							datNext = statusWord;
						end
						stateNext = FifoPkg::StAck;
					end
				end
			end
			FifoPkg::StPopWait:
			begin
				// capture the popped word and finish the cycle
				if (rxPopValid)
				begin
					datLoad = 1'b1;
					datNext = rxPopData;
					stateNext = FifoPkg::StAck;
				end
			end
			FifoPkg::StAck:
			begin
				// strobe still high here, take no action on it
				stateNext = FifoPkg::StIdle;
			end
			default:
			begin
				stateNext = FifoPkg::StIdle;
			end
		endcase
	end

	// state register
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			state <= FifoPkg::StIdle;
		end
		else
		begin
			state <= stateNext;
		end
	end

	// read data register
	always_ff @(posedge iCLK)
	begin
		if (datLoad)
		begin
			wbDatR <= datNext;
		end
	end

endmodule

`default_nettype wire

// ==== src/SyncFifoController.sv ====
`timescale 1ns/10ps
`default_nettype none

module SyncFifoController
(
	input wire logic iCLK,
	input wire logic inARST,
	// write side
	input wire FifoPkg::tData iWd,
	input wire logic iWe,
	output logic oFull,
	// read side
	output wire FifoPkg::tData oRd,
	input wire logic iRe,
	output logic oRvd,
	output logic oEmp
);

	// ----------------------------------------
	// pointers
	// ----------------------------------------
	FifoPkg::tAddr wrPtr;
	FifoPkg::tAddr rdPtr;
	// write pointer one step ahead, used for full
	FifoPkg::tAddr wrPtrNext;
	// accepted write and read this cycle
	logic wrOk;
	logic rdOk;

	assign wrPtrNext = wrPtr + 1'b1;

	// full when the next write would land on the read pointer
	// so one entry always stays unused
	assign oFull = (wrPtrNext == rdPtr);
	// empty when both pointers meet
	assign oEmp = (wrPtr == rdPtr);

	// gate requests with the flags here
	// callers may raise iWe or iRe freely
	assign wrOk = iWe & ~oFull;
	assign rdOk = iRe & ~oEmp;

	// write pointer
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			wrPtr <= '0;
		end
		else if (wrOk)
		begin
			wrPtr <= wrPtrNext;
		end
	end

	// read pointer
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			rdPtr <= '0;
		end
		else if (rdOk)
		begin
			rdPtr <= rdPtr + 1'b1;
		end
	end

	// read valid strobe
	// high for exactly one cycle after each accepted pop,
	// lines up with the slice output register
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			oRvd <= 1'b0;
		end
		else
		begin
			oRvd <= rdOk;
		end
	end

	// ----------------------------------------
	// memory slices
	// ----------------------------------------
	// each slice holds its own byte lane of the word
	// all slices share pointers and enables
	for (genvar g = 0; g < FifoPkg::SliceCount; g++)
	begin : genSlice
		SdpBramSlice
		#(
			.DataWidth(FifoPkg::SliceWidth),
			.AddrWidth(FifoPkg::AddrWidth)
		)
		uSlice
		(
			.iCLK(iCLK),
			// write lane
			.iWd(iWd[g*FifoPkg::SliceWidth +: FifoPkg::SliceWidth]),
			.iWa(wrPtr),
			.iWe(wrOk),
			// read lane
			.iRa(rdPtr),
			.iRe(rdOk),
			.oRd(oRd[g*FifoPkg::SliceWidth +: FifoPkg::SliceWidth])
		);
	end

endmodule

`default_nettype wire

// ==== src/SdpBramSlice.sv ====
`timescale 1ns/10ps
`default_nettype none

module SdpBramSlice
#(
	parameter int unsigned DataWidth = FifoPkg::SliceWidth,
	parameter int unsigned AddrWidth = FifoPkg::AddrWidth
)
(
	input wire logic iCLK,
	// write side
	input wire logic [DataWidth-1:0] iWd,
	input wire FifoPkg::tAddr iWa,
	input wire logic iWe,
	// read side
	input wire FifoPkg::tAddr iRa,
	input wire logic iRe,
	output logic [DataWidth-1:0] oRd
);

	// one entry per pointer value
	localparam int unsigned Depth = 1 << AddrWidth;

	// storage array
	logic [DataWidth-1:0] mem [0:Depth-1];

	// write port
	always_ff @(posedge iCLK)
	begin
		if (iWe)
		begin
			mem[iWa] <= iWd;
		end
	end

	// registered read, word valid the cycle after iRe
	always_ff @(posedge iCLK)
	begin
		if (iRe)
		begin
			oRd <= mem[iRa];
		end
	end

endmodule

`default_nettype wire

// ==== src/FifoPkg.sv ====
`default_nettype none

package FifoPkg;

	// ----------------------------------------
	// widths and depths
	// ----------------------------------------
	// one fifo word, same as the wishbone data bus
	localparam int unsigned DataWidth = 16;
	// 16 entries, one always kept free
	localparam int unsigned FifoDepth = 16;
	localparam int unsigned AddrWidth = $clog2(FifoDepth);
	// memory split into byte slices
	localparam int unsigned SliceWidth = 8;
	localparam int unsigned SliceCount = DataWidth / SliceWidth;
	// word address on the bus
	localparam int unsigned WbAdrWidth = 2;

	// ----------------------------------------
	// vector types
	// ----------------------------------------
	typedef logic [DataWidth-1:0] tData;
	typedef logic [AddrWidth-1:0] tAddr;
	typedef logic [WbAdrWidth-1:0] tWbAdr;

	// register map
	localparam tWbAdr AdrData = 2'd0;
	localparam tWbAdr AdrStatus = 2'd1;

	// status word bit positions, all other bits read zero
	localparam int unsigned StTxFull = 0;
	localparam int unsigned StTxEmpty = 1;
	localparam int unsigned StRxFull = 2;
	localparam int unsigned StRxEmpty = 3;

	// bus side fsm
	typedef enum logic [1:0]
	{
		StIdle,
		StPopWait,
		StAck
	} tWbState;

endpackage

`default_nettype wire
